// ==== scroll_tiles.f ====
verilog/scroll_pkg.sv
verilog/scroll_regs.sv
verilog/scroll_map_reader.sv
verilog/scroll_tile_shift.sv
verilog/line_buffer.sv
verilog/scroll_layer.sv
tests/scroll_layer_tb.sv

// ==== tests/scroll_cases.txt ====
// test name | slow 0/1 | map addr data | tile addr data | reg sel(dec) data
// at line col | chk line col pixel, line is vrender at render time, shown two lines later
test reset_zero
chk 0 0 000
chk 0 319 000
end
test zero_scroll
map 1080 8040
map 1085 0085
map 10a7 80c3
tile 040a 00f0ccaa
tile 085a 0081ff01
tile 0c3a 000f3355
at 19 8
reg 0 4321
chk 21 0 40f
chk 21 6 409
chk 21 20 000
chk 21 44 012
chk 21 312 418
chk 21 319 41f
end
test wrap_quadrant
map 1960 0180
map 197f 0100
map 2140 8140
tile 1800 000000ff
tile 1000 00ff0000
tile 1400 0000ff00
at 38 8
reg 1 0100
reg 2 0100
chk 40 0 031
chk 40 255 024
chk 40 256 42a
chk 40 263 42a
end
test flip
at 100 8
reg 1 0000
reg 2 0000
reg 3 0001
chk 202 0 41f
chk 202 279 016
chk 202 319 40f
end
test shadow_hscr
map 16c1 01c0
tile 1c06 00ffffff
tile 1c08 00ffffff
at 210 8
reg 3 0000
at 220 150
reg 1 0008
chk 219 8 03f
chk 219 16 000
chk 220 8 000
chk 220 16 03f
end
test slow_memory
slow 1
at 19 8
reg 1 0000
chk 21 0 40f
chk 21 6 409
chk 21 44 012
chk 21 319 41f
end

// ==== tests/scroll_layer_tb.sv ====
/*
 * testbench for the scroll tile layer
 *   clock, reset and video timing
 *   map and tile memory models with random ok delay
 *   case file replay, register writes and pixel checks
 */
`timescale 1ns/1ps

module scroll_layer_tb;
    import scroll_pkg::*;

    localparam int wait_limit = 600000;  // clocks, more than a frame

    logic               clk, rst, pxl2_cen, LHBL;
    logic [8:0]         vrender, hdump;
    logic               reg_we;
    reg_sel_t           reg_sel;
    logic [15:0]        reg_wdata;
    logic [map_aw-1:0]  map_addr, map_seen;
    logic               map_ok, tile_ok;
    logic [15:0]        map_data;
    logic [tile_aw-1:0] tile_addr, tile_seen;
    logic [31:0]        tile_data;
    pixel_t             pxl;
    logic [15:0]        map_mem [1<<map_aw];
    logic [31:0]        tile_mem [1<<tile_aw];
    logic [1:0]         div, map_wait, tile_wait;
    logic               slow;     // random ok delays on
    logic               aborted;
    int                 checks, errors, tests, test_errors;

    scroll_layer scroll_layer_inst (
        .clk(clk), .rst(rst), .pxl2_cen(pxl2_cen), .LHBL(LHBL),
        .vrender(vrender), .hdump(hdump),
        .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .map_addr(map_addr), .map_ok(map_ok), .map_data(map_data),
        .tile_addr(tile_addr), .tile_ok(tile_ok), .tile_data(tile_data),
        .pxl(pxl)
    );

    always #4 clk = ~clk;

    // video timing, hdump steps every second pxl2_cen
    always @(posedge clk) begin
        div      <= div + 2'd1;
        pxl2_cen <= div[0];
        if (div == 2'd3) begin
            if (hdump == 9'd383) begin
                hdump   <= '0;
                vrender <= (vrender == 9'd261) ? '0 : vrender + 9'd1;
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
        LHBL <= hdump < 9'(line_w);  // low in blanking
    end

    function automatic logic [1:0] ok_delay();
        return slow ? 2'($urandom % 4) : 2'd0;
    endfunction

    // ok drops on a new address, returns after the delay
    always @(posedge clk) begin
        if (map_addr != map_seen) begin
            map_seen <= map_addr;
            map_wait <= ok_delay();
            map_ok   <= 1'b0;
        end else if (map_wait != 2'd0) begin
            map_wait <= map_wait - 2'd1;
        end else begin
            map_ok   <= 1'b1;
            map_data <= map_mem[map_addr];
        end
    end

    always @(posedge clk) begin
        if (tile_addr != tile_seen) begin
            tile_seen <= tile_addr;
            tile_wait <= ok_delay();
            tile_ok   <= 1'b0;
        end else if (tile_wait != 2'd0) begin
            tile_wait <= tile_wait - 2'd1;
        end else begin
            tile_ok   <= 1'b1;
            tile_data <= tile_mem[tile_addr];
        end
    end

    task automatic write_reg(input logic [1:0] sel, input logic [15:0] data);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_sel   <= reg_sel_t'(sel);
        reg_wdata <= data;
        @(posedge clk);
        reg_we    <= 1'b0;  // one clock strobe
    endtask

    task automatic wait_video(input int line, input int col);
        int n;
        n = 0;
        while (!aborted && !(vrender == 9'(line) && hdump == 9'(col))) begin
            @(posedge clk);
            n++;
            if (n > wait_limit) begin
                $display("timeout waiting for line %0d column %0d", line, col);
                aborted = 1'b1;
            end
        end
    endtask

    // rendered scan shows two lines later
    task automatic check_pixel(input int line, input int col,
                               input logic [pxl_w-1:0] expected,
                               input logic [8*24-1:0] name);
        wait_video((line + 2) % 262, col);
        if (!aborted) begin
            @(posedge clk);
            @(negedge clk);  // pxl settled one clock after the column
            checks++;
            if (pxl !== expected) begin
                $display("mismatch %0s line %0d col %0d expected %03h actual %03h",
                         name, line, col, expected, pxl);
                errors++;
                test_errors++;
            end
        end
    endtask

    // one memory address port against its expected value
    task automatic compare_addr(input logic [8*24-1:0] name,
                                input logic [8*12-1:0] port,
                                input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch %0s %0s expected %0h actual %0h",
                     name, port, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input logic [8*24-1:0] name);
        $display("%0s: %0s, %0d errors", name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
    endtask

    initial begin
        int              fd, n, a, b, c, seed;
        logic [8*80-1:0] text;
        logic [8*8-1:0]  cmd;
        logic [8*24-1:0] name;
        seed = $urandom(32'h29e2_ea46);
        clk = 1'b0;
        rst = 1'b1;
        div = '0;
        hdump = '0;
        vrender = '0;
        LHBL = 1'b1;
        pxl2_cen = 1'b0;
        reg_we = 1'b0;
        reg_sel = sel_pages;
        reg_wdata = '0;
        map_ok = 1'b0;
        map_data = '0;
        map_seen = '0;
        map_wait = '0;
        tile_ok = 1'b0;
        tile_data = '0;
        tile_seen = '0;
        tile_wait = '0;
        slow = 1'b0;
        aborted = 1'b0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_errors = 0;
        name = "reset_addr";
        for (int i = 0; i < (1 << map_aw); i++) map_mem[i] = '0;
        for (int i = 0; i < (1 << tile_aw); i++) tile_mem[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // both address ports idle at zero until the first line start
        tests++;
        @(negedge clk);
        compare_addr(name, "map_addr", 32'd0, map_addr);
        compare_addr(name, "tile_addr", 32'd0, tile_addr);
        report_test(name);
        fd = $fopen("tests/scroll_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file tests/scroll_cases.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            text = '0;
            cmd  = '0;
            n = $fgets(text, fd);
            if ($sscanf(text, "%s", cmd) == 1) begin
                if (cmd == "test") begin
                    n = $sscanf(text, "%s %s", cmd, name);
                    test_errors = 0;
                    tests++;
                end else if (cmd == "slow") begin
                    n = $sscanf(text, "%s %d", cmd, a);
                    slow = a[0];
                end else if (cmd == "map") begin
                    n = $sscanf(text, "%s %h %h", cmd, a, b);
                    map_mem[a] = b[15:0];
                end else if (cmd == "tile") begin
                    n = $sscanf(text, "%s %h %h", cmd, a, b);
                    tile_mem[a] = b;
                end else if (cmd == "reg") begin
                    n = $sscanf(text, "%s %d %h", cmd, a, b);
                    write_reg(a[1:0], b[15:0]);
                end else if (cmd == "at") begin
                    n = $sscanf(text, "%s %d %d", cmd, a, b);
                    wait_video(a, b);
                end else if (cmd == "chk") begin
                    n = $sscanf(text, "%s %d %d %h", cmd, a, b, c);
                    check_pixel(a, b, c[pxl_w-1:0], name);
                end else if (cmd == "end") begin
                    report_test(name);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (aborted || errors != 0 || checks == 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// ==== verilog/line_buffer.sv ====
/*
 * two bank line buffer
 *   render bank written by the shifter
 *   display bank read at hdump, mirrored under flip
 *   read erases, banks swap at line start
 */
`timescale 1ns/1ps

module line_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               line_start,
    input  logic               flip,
    input  logic [8:0]         hdump,
    input  logic               wr_en,
    input  logic [8:0]         wr_addr,
    input  scroll_pkg::pixel_t wr_data,
    output scroll_pkg::pixel_t pxl
);
    import scroll_pkg::*;

    pixel_t                 mem [2][line_w];
    logic [1:0][line_w-1:0] valid;    // cleared entries read as zero
    logic                   wr_bank;
    logic                   rd_bank;
    logic [8:0]             rd_addr;
    logic [8:0]             rd_last;  // column already taken
    logic                   rd_in, wr_in, rd_new;

    assign rd_bank = ~wr_bank;
    assign rd_in   = hdump < 9'(line_w);
    assign rd_addr = flip ? 9'(line_w - 1) - hdump : hdump;
    assign wr_in   = wr_en & (wr_addr < 9'(line_w));
    // hdump stays on a column for several clocks, erase once
    assign rd_new  = rd_in & (rd_addr != rd_last);

    always_ff @(posedge clk) begin
        if (wr_in) mem[wr_bank][wr_addr] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_bank <= 1'b0;
            valid   <= '0;
            rd_last <= '1;
            pxl     <= '0;
        end else begin
            if (line_start) begin
                wr_bank <= ~wr_bank;
                rd_last <= '1;  // never matches an in-range column
            end else if (rd_new) begin
                rd_last <= rd_addr;
            end
            if (wr_in) valid[wr_bank][wr_addr] <= 1'b1;
            if (!rd_in) begin
                pxl <= pixel_t'({pxl_w{1'b0}});  // blanking reads zero
            end else if (rd_new) begin
                pxl <= valid[rd_bank][rd_addr] ? mem[rd_bank][rd_addr] : '0;
                valid[rd_bank][rd_addr] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/scroll_layer.sv ====
/*
 * scroll tile layer top level
 *   register block, map reader, tile shifter, line buffer
 */
`timescale 1ns/1ps

module scroll_layer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pxl2_cen,
    input  logic                           LHBL,
    input  logic [8:0]                     vrender,
    input  logic [8:0]                     hdump,
    // cpu side
    input  logic                           reg_we,
    input  scroll_pkg::reg_sel_t           reg_sel,
    input  logic [15:0]                    reg_wdata,
    // map memory
    output logic [scroll_pkg::map_aw-1:0]  map_addr,
    input  logic                           map_ok,
    input  logic [15:0]                    map_data,
    // tile rom
    output logic [scroll_pkg::tile_aw-1:0] tile_addr,
    input  logic                           tile_ok,
    input  logic [31:0]                    tile_data,
    output scroll_pkg::pixel_t             pxl
);
    import scroll_pkg::*;

    scroll_regs_t regs;
    logic         line_start;
    logic [9:0]   hpos;
    logic [2:0]   vpos_row;
    logic         draw, busy, done;
    logic [8:0]   hscan;      // write column
    logic         wr_en;
    pixel_t       wr_data;

    scroll_regs scroll_regs_inst (
        .clk(clk), .rst(rst), .LHBL(LHBL),
        .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .regs(regs), .line_start(line_start)
    );

    scroll_map_reader scroll_map_reader_inst (
        .clk(clk), .rst(rst), .line_start(line_start), .regs(regs),
        .vrender(vrender), .hscan(hscan), .busy(busy), .done(done),
        .map_ok(map_ok), .tile_ok(tile_ok), .map_addr(map_addr),
        .hpos(hpos), .vpos_row(vpos_row), .draw(draw)
    );

    scroll_tile_shift scroll_tile_shift_inst (
        .clk(clk), .rst(rst), .pxl2_cen(pxl2_cen), .line_start(line_start),
        .draw(draw), .hpos(hpos), .vpos_row(vpos_row), .map_data(map_data),
        .tile_ok(tile_ok), .tile_data(tile_data), .tile_addr(tile_addr),
        .busy(busy), .done(done), .hscan(hscan),
        .wr_en(wr_en), .wr_data(wr_data)
    );

    // flip mirrors the read side only, rows are flipped in the reader
    line_buffer line_buffer_inst (
        .clk(clk), .rst(rst), .line_start(line_start), .flip(regs.flip),
        .hdump(hdump), .wr_en(wr_en), .wr_addr(hscan), .wr_data(wr_data),
        .pxl(pxl)
    );

endmodule

// ==== verilog/scroll_map_reader.sv ====
/*
 * map reader for the scroll layer
 *   vertical scan latch with flip
 *   horizontal and vertical scroll with wrap
 *   page quadrant select and map address
 *   fetch FSM issuing draw to the tile shifter
 */
`timescale 1ns/1ps

module scroll_map_reader (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           line_start,
    input  scroll_pkg::scroll_regs_t       regs,
    input  logic [8:0]                     vrender,
    input  logic [8:0]                     hscan,
    input  logic                           busy,
    input  logic                           done,
    input  logic                           map_ok,
    input  logic                           tile_ok,
    output logic [scroll_pkg::map_aw-1:0]  map_addr,
    output logic [9:0]                     hpos,
    output logic [2:0]                     vpos_row,
    output logic                           draw
);
    import scroll_pkg::*;

    fetch_st_t  st;
    logic [8:0] vscan;  // line being rendered
    logic [8:0] vpos;   // scrolled vertical position
    logic [3:0] page;
    logic       mem_rdy;

    // scroll arithmetic, both wrap naturally
    assign hpos     = {1'b0, hscan} - regs.hscr;  // mod 1024
    assign vpos     = vscan + regs.vscr;          // mod 512
    assign vpos_row = vpos[2:0];                  // row inside the tile

    // quadrant from the two overflow bits
    always_comb begin
        case ({vpos[8], hpos[9]})
            2'b10:   page = regs.pages[15:12];  // upper left
            2'b11:   page = regs.pages[11:8];   // upper right
            2'b00:   page = regs.pages[7:4];    // lower left
            default: page = regs.pages[3:0];    // lower right
        endcase
    end

    // both memories settled and shifter free
    assign mem_rdy = map_ok & tile_ok & ~busy;

    // scan line for the whole render
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vscan <= '0;
        end else if (line_start) begin
            // regs already hold the new values here
            vscan <= regs.flip ? 9'(flip_line) - vrender : vrender;
        end
    end

    // fetch loop
    // fs_addr waits until the last tile is fully written, since the
    // next address comes from the advanced hscan
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= fs_addr;
            map_addr <= '0;
            draw     <= 1'b0;
        end else if (line_start || done) begin
            st   <= fs_addr;  // idle between lines
            draw <= 1'b0;
        end else begin
            draw <= 1'b0;
            case (st)
                fs_addr: begin
                    if (!busy && !draw) begin
                        map_addr <= {page, vpos[7:3], hpos[8:3]};
                        st       <= fs_wait_a;
                    end
                end
                fs_wait_a: st <= fs_wait_b;  // let map_ok follow the new address
                fs_wait_b: st <= fs_draw;
                fs_draw: begin
                    // stall here on slow memory
                    if (mem_rdy) begin
                        draw <= 1'b1;
                        st   <= fs_addr;
                    end
                end
                default: st <= fs_addr;
            endcase
        end
    end

endmodule

// ==== verilog/scroll_pkg.sv ====
/*
 * shared definitions for the scroll tile layer
 *   line and address sizes
 *   register write opcodes and the active register set
 *   map word and output pixel layouts
 *   map reader fetch states
 */
package scroll_pkg;

    // video geometry
    localparam int line_w    = 320;  // visible pixels per line
    localparam int flip_line = 223;  // last visible line, mirror point for flip

    // memory and pixel widths
    localparam int map_aw  = 15;
    localparam int tile_aw = 17;
    localparam int pxl_w   = 11;     // 1 prio + 7 palette + 3 colour

    // cpu write port opcode
    typedef enum logic [1:0] {
        sel_pages = 2'd0,
        sel_hscr  = 2'd1,
        sel_vscr  = 2'd2,
        sel_ctrl  = 2'd3
    } reg_sel_t;

    // active register set, loaded at line start
    typedef struct packed {
        logic [15:0] pages;  // four page nibbles, one per quadrant
        logic [9:0]  hscr;
        logic [8:0]  vscr;
        logic        flip;
    } scroll_regs_t;

    // map memory word
    // palette overlaps code, it is bits 12:6 of the word
    typedef struct packed {
        logic        prio;
        logic [1:0]  spare;
        logic [12:0] code;
    } map_entry_t;

    typedef struct packed {
        logic       prio;
        logic [6:0] palette;
        logic [2:0] colour;  // plane 2 in the msb
    } pixel_t;

    // map reader loop
    typedef enum logic [1:0] {
        fs_addr,
        fs_wait_a,
        fs_wait_b,
        fs_draw
    } fetch_st_t;

endpackage

// ==== verilog/scroll_regs.sv ====
/*
 * scroll register block
 *   cpu write strobe into the shadow copy
 *   lhbl falling edge detect, line_start pulse
 *   shadow to active copy at line start
 */
`timescale 1ns/1ps

module scroll_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     LHBL,
    input  logic                     reg_we,
    input  scroll_pkg::reg_sel_t     reg_sel,
    input  logic [15:0]              reg_wdata,
    output scroll_pkg::scroll_regs_t regs,
    output logic                     line_start
);
    import scroll_pkg::*;

    scroll_regs_t shadow;  // cpu side copy
    logic         lhbl_l;  // lhbl one clock late
    logic         hb_fall;

    // blanking starts when lhbl goes low
    assign hb_fall = lhbl_l & ~LHBL;

    // cpu writes, may land anywhere in the line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow <= '0;
        end else if (reg_we) begin
            case (reg_sel)
                sel_pages: shadow.pages <= reg_wdata;
                sel_hscr:  shadow.hscr  <= reg_wdata[9:0];
                sel_vscr:  shadow.vscr  <= reg_wdata[8:0];
                sel_ctrl:  shadow.flip  <= reg_wdata[0];  // other ctrl bits unused
                default:   ;
            endcase
        end
    end

    // active copy only moves at the blanking edge
    // so a line in flight keeps its scroll values
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l     <= 1'b0;  // no false edge out of reset
            line_start <= 1'b0;
            regs       <= '0;
        end else begin
            lhbl_l     <= LHBL;
            line_start <= hb_fall;
            if (hb_fall) begin
                regs <= shadow;  // same clock as the line_start pulse
            end
        end
    end

endmodule

// ==== verilog/scroll_tile_shift.sv ====
/*
 * tile shifter
 *   map entry latch and tile row address
 *   tile_ok qualify and plane load
 *   pixel shift out, line buffer writes, busy and done
 */
`timescale 1ns/1ps

module scroll_tile_shift (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pxl2_cen,
    input  logic                            line_start,
    input  logic                            draw,
    input  logic [9:0]                      hpos,
    input  logic [2:0]                      vpos_row,
    input  logic [15:0]                     map_data,
    input  logic                            tile_ok,
    input  logic [31:0]                     tile_data,
    output logic [scroll_pkg::tile_aw-1:0]  tile_addr,
    output logic                            busy,
    output logic                            done,
    output logic [8:0]                      hscan,
    output logic                            wr_en,
    output scroll_pkg::pixel_t              wr_data
);
    import scroll_pkg::*;

    map_entry_t  map_word;   // view of the incoming map data
    map_entry_t  entry;      // latched for the tile being drawn
    logic [23:0] planes;     // plane 2 in 23:16, plane 0 in 7:0
    logic [1:0]  tile_good;  // tile_ok history
    logic        loaded;     // planes hold this tile's row
    logic        take;
    logic        load;

    assign map_word = map_data;
    assign take     = draw & ~done;
    assign load     = busy & ~loaded & (tile_good == 2'b11);
    assign wr_en    = busy & loaded & pxl2_cen;  // one pixel per cen

    always_comb begin
        wr_data.prio    = entry.prio;
        wr_data.palette = entry.code[12:6];  // overlaps the code field
        wr_data.colour  = {planes[23], planes[15], planes[7]};
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (take) begin
            entry <= map_word;
        end
        if (load) begin
            planes <= tile_data[23:0];  // upper byte unused
        end else if (wr_en) begin
            planes <= {planes[22:16], 1'b0, planes[14:8], 1'b0, planes[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_addr <= '0;
            busy      <= 1'b0;
            done      <= 1'b1;  // nothing renders before a line start
            hscan     <= '0;
            tile_good <= '0;
            loaded    <= 1'b0;
        end else if (line_start) begin
            hscan     <= '0;
            done      <= 1'b0;
            busy      <= 1'b0;
            loaded    <= 1'b0;
            tile_good <= '0;
        end else begin
            if (take) begin
                tile_addr <= {map_word.code, vpos_row, 1'b0};
                busy      <= 1'b1;
                loaded    <= 1'b0;
                tile_good <= '0;  // old ok level does not count
            end else if (busy) begin
                tile_good <= {tile_good[0], tile_ok};
            end
            if (load) loaded <= 1'b1;
            if (wr_en) begin
                hscan <= hscan + 9'd1;
                if (hscan == 9'(line_w - 1)) begin
                    done <= 1'b1;  // last column written
                    busy <= 1'b0;
                end else if (hpos[2:0] == 3'd7) begin
                    busy <= 1'b0;  // tile boundary, partial first tile too
                end
            end
        end
    end

endmodule
